// ==== uart_peripheral.f ====
+incdir+source
source/uart_bus_pkg.sv
source/uart_line_pkg.sv
source/uart_transmitter.sv
source/uart_receiver.sv
source/uart_bus_interface.sv
source/uart_peripheral.sv
bench/uart_peripheral_checker.sv
bench/uart_peripheral_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# builds the testbench with Verilator and runs it from the project root
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
  -f uart_peripheral.f \
  --top-module uart_peripheral_tb \
  -o uart_peripheral_sim

./obj_dir/uart_peripheral_sim > sim.log 2>&1
cat sim.log

if grep -q "^sim passed$" sim.log; then
  exit 0
else
  exit 1
fi

// ==== bench/uart_peripheral_tb.sv ====
`include "uart_consts.svh"

module uart_peripheral_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int CPB = `UART_CYCLES_PER_BIT;
  localparam int FRAME_CYCLES = 12 * CPB;
  // tests take 1, 1, 2, 2 and 1 frames, plus reset, notes and bus cycles
  localparam int RUN_CYCLES = 7 * FRAME_CYCLES + 40;
  localparam int CYCLE_LIMIT = RUN_CYCLES * 3 / 2;

  logic        clock;
  logic        reset_internal;
  logic [4:0]  rw_address;
  logic [31:0] read_data;
  logic        read_request;
  logic        read_response;
  logic [7:0]  write_data;
  logic        write_request;
  logic        write_response;
  logic        uart_rx;
  logic        uart_tx;
  logic        uart_irq;
  logic        uart_irq_response;
  logic        note_valid;
  logic [1:0]  note_kind;
  logic [7:0]  note_byte;
  int          scoreboard_errors;
  logic [31:0] lfsr_state;
  int          cycle_count = 0;

  uart_peripheral DUT (
    .clock             (clock),
    .reset_internal    (reset_internal),
    .rw_address        (rw_address),
    .read_data         (read_data),
    .read_request      (read_request),
    .read_response     (read_response),
    .write_data        (write_data),
    .write_request     (write_request),
    .write_response    (write_response),
    .uart_rx           (uart_rx),
    .uart_tx           (uart_tx),
    .uart_irq          (uart_irq),
    .uart_irq_response (uart_irq_response)
  );

  uart_peripheral_checker scoreboard (
    .clock             (clock),
    .reset_internal    (reset_internal),
    .rw_address        (rw_address),
    .read_data         (read_data),
    .read_request      (read_request),
    .read_response     (read_response),
    .write_data        (write_data),
    .write_request     (write_request),
    .write_response    (write_response),
    .uart_rx           (uart_rx),
    .uart_tx           (uart_tx),
    .uart_irq          (uart_irq),
    .uart_irq_response (uart_irq_response),
    .note_valid        (note_valid),
    .note_kind         (note_kind),
    .note_byte         (note_byte),
    .error_count       (scoreboard_errors)
  );

  initial begin
    clock = 1'b0;
    forever begin
      #10;
      clock = ~clock;
    end
  end

  always @(posedge clock) begin
    cycle_count++;
    if (cycle_count >= CYCLE_LIMIT) begin
      $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("sim failed");
      $finish;
    end
  end

  // taps 32, 22, 2 and 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] state);
    return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
  endfunction

  task random_byte(output logic [7:0] value);
    for (int i = 0; i < 8; i++) begin
      lfsr_state = lfsr_step(lfsr_state);
      value[i] = lfsr_state[0];
    end
  endtask

  task wait_cycles(input int count);
    repeat (count) begin
      @(posedge clock);
      #2;
    end
  endtask

  task send_note(input logic [1:0] kind, input logic [7:0] value);
    note_kind = kind;
    note_byte = value;
    note_valid = 1'b1;
    wait_cycles(1);
    note_valid = 1'b0;
  endtask

  task bus_write(input logic [4:0] address, input logic [7:0] data);
    rw_address = address;
    write_data = data;
    write_request = 1'b1;
    wait_cycles(1);
    write_request = 1'b0;
    while (!write_response) begin
      wait_cycles(1);
    end
  endtask

  task bus_read(input logic [4:0] address, output uart_bus_pkg::read_word word);
    rw_address = address;
    read_request = 1'b1;
    wait_cycles(1);
    read_request = 1'b0;
    while (!read_response) begin
      wait_cycles(1);
    end
    word = read_data;
  endtask

  task wait_tx_ready();
    uart_bus_pkg::read_word word;
    word = '0;
    while (word.status.tx_ready !== 1'b1) begin
      bus_read(uart_bus_pkg::REG_TX_STATUS, word);
    end
  endtask

  task drive_rx_frame(input logic [7:0] value);
    logic [9:0] frame;
    frame = {1'b1, value, 1'b0};
    for (int i = 0; i < 10; i++) begin
      uart_rx = frame[i];
      wait_cycles(CPB);
    end
  endtask

  initial begin
    logic [7:0] data;
    uart_bus_pkg::read_word word;
    reset_internal = 1'b1;
    rw_address = '0;
    read_request = 1'b0;
    write_request = 1'b0;
    write_data = '0;
    uart_rx = 1'b1;
    uart_irq_response = 1'b0;
    note_valid = 1'b0;
    note_kind = '0;
    note_byte = '0;
    lfsr_state = 32'h11;
    repeat (5) @(posedge clock);
    #2;
    reset_internal = 1'b0;
    wait_cycles(2);

    random_byte(data);
    send_note(2'd0, data);
    bus_write(uart_bus_pkg::REG_TX_STATUS, data);
    wait_tx_ready();
    send_note(2'd2, 8'd1);

    random_byte(data);
    send_note(2'd0, data);
    bus_write(uart_bus_pkg::REG_TX_STATUS, data);
    bus_read(uart_bus_pkg::REG_TX_STATUS, word);
    wait_cycles(10 * CPB);
    bus_read(uart_bus_pkg::REG_TX_STATUS, word);
    send_note(2'd2, 8'd2);

    // the second byte arrives in the middle of the first frame
    random_byte(data);
    send_note(2'd0, data);
    bus_write(uart_bus_pkg::REG_TX_STATUS, data);
    wait_cycles(3 * CPB);
    random_byte(data);
    bus_write(uart_bus_pkg::REG_TX_STATUS, data);
    wait_tx_ready();
    wait_cycles(2 * CPB);
    bus_read(uart_bus_pkg::REG_TX_STATUS, word);
    send_note(2'd2, 8'd3);

    random_byte(data);
    send_note(2'd1, data);
    drive_rx_frame(data);
    while (!uart_irq) begin
      wait_cycles(1);
    end
    bus_read(uart_bus_pkg::REG_RX_DATA, word);
    wait_cycles(3);
    uart_irq_response = 1'b1;
    wait_cycles(1);
    uart_irq_response = 1'b0;
    wait_cycles(2);
    bus_read(uart_bus_pkg::REG_RX_DATA, word);
    send_note(2'd2, 8'd4);

    bus_read(5'h08, word);
    bus_read(5'h1f, word);
    bus_write(5'h0c, 8'h5a);
    bus_read(uart_bus_pkg::REG_TX_STATUS, word);
    bus_read(uart_bus_pkg::REG_RX_DATA, word);
    wait_cycles(CPB);
    send_note(2'd2, 8'd5);

    send_note(2'd3, 8'd0);
    wait_cycles(1);
    if (scoreboard_errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

// ==== bench/uart_peripheral_checker.sv ====
`include "uart_consts.svh"

module uart_peripheral_checker (
  input  logic        clock,
  input  logic        reset_internal,
  input  logic [4:0]  rw_address,
  input  logic [31:0] read_data,
  input  logic        read_request,
  input  logic        read_response,
  input  logic [7:0]  write_data,
  input  logic        write_request,
  input  logic        write_response,
  input  logic        uart_rx,
  input  logic        uart_tx,
  input  logic        uart_irq,
  input  logic        uart_irq_response,
  input  logic        note_valid,
  input  logic [1:0]  note_kind,
  input  logic [7:0]  note_byte,
  output int          error_count
);
  timeunit 1ns;
  timeprecision 100ps;

  localparam int CPB = `UART_CYCLES_PER_BIT;
  // busy from the edge after the accepted write until the stop bit ends
  localparam int TX_BUSY_CYCLES = 10 * CPB + 1;

  int errors_total = 0;
  int checks_total = 0;
  int test_errors = 0;
  int test_checks = 0;
  int tests_ok = 0;
  int tests_bad = 0;

  logic                   last_read_request;
  logic                   last_write_request;
  uart_bus_pkg::read_word expected_word;
  logic                   last_tx;
  logic                   last_irq;
  logic                   irq_known;
  logic                   irq_expected;
  int                     tx_busy_left;
  int                     tx_offset;
  logic [3:0]             sample_index;
  logic [9:0]             tx_samples;
  logic                   tx_pending = 1'b0;
  logic [7:0]             tx_pending_byte;
  logic                   rx_pending = 1'b0;
  logic [7:0]             rx_pending_byte;
  logic [7:0]             last_rx_byte = 8'h00;

  assign error_count = errors_total;

  // start bit low, data least significant bit first, stop bit high
  function automatic logic [9:0] expected_frame(input logic [7:0] data);
    logic [9:0] frame;
    frame[0] = 1'b0;
    for (int i = 0; i < 8; i++) begin
      frame[i + 1] = data[i];
    end
    frame[9] = 1'b1;
    return frame;
  endfunction

  function automatic uart_bus_pkg::read_word expected_read(input logic [4:0] address,
      input logic [7:0] last_rx, input logic frame_busy);
    uart_bus_pkg::read_word word;
    word = '0;
    case (address)
      uart_bus_pkg::REG_TX_STATUS: word.status.tx_ready = !frame_busy;
      uart_bus_pkg::REG_RX_DATA:   word.rx.rx_byte = last_rx;
      default:                     word = '0;
    endcase
    return word;
  endfunction

  function automatic string test_name(input int id);
    case (id)
      1:       return "transmit frame";
      2:       return "status flag";
      3:       return "dropped write";
      4:       return "receive";
      5:       return "responses and unmapped reads";
      default: return "unnamed";
    endcase
  endfunction

  task check_value(input string name, input logic [31:0] expected, input logic [31:0] actual);
    checks_total++;
    test_checks++;
    if (actual !== expected) begin
      $display("FAIL %s expected 0x%0h got 0x%0h at %0t", name, expected, actual, $time);
      errors_total++;
      test_errors++;
    end
  endtask

  task report_problem(input string text);
    $display("error: %s at %0t", text, $time);
    errors_total++;
    test_errors++;
  endtask

  task finish_test(input int id);
    if (tx_pending || tx_offset != 0) begin
      report_problem("a written byte never came out complete on uart_tx");
    end
    if (rx_pending) begin
      report_problem("uart_irq never rose for the frame driven on uart_rx");
    end
    if (test_errors == 0) begin
      tests_ok++;
      $display("test %0d %s: ok, %0d checks", id, test_name(id), test_checks);
    end else begin
      tests_bad++;
      $display("test %0d %s: %0d errors", id, test_name(id), test_errors);
    end
    test_errors = 0;
    test_checks = 0;
  endtask

  always @(posedge clock) begin
    if (reset_internal) begin
      last_read_request = 1'b0;
      last_write_request = 1'b0;
      expected_word = '0;
      last_tx = 1'b1;
      last_irq = 1'b0;
      irq_known = 1'b0;
      irq_expected = 1'b0;
      tx_busy_left = 0;
      tx_offset = 0;
      tx_samples = '0;
    end else begin
      // outputs seen here belong to the requests of the previous edge
      check_value("read_response", 32'(last_read_request), 32'(read_response));
      check_value("write_response", 32'(last_write_request), 32'(write_response));
      check_value("read_data", last_read_request ? expected_word : 32'h0, read_data);

      if (irq_known) begin
        check_value("uart_irq", 32'(irq_expected), 32'(uart_irq));
      end
      if (uart_irq && !last_irq) begin
        if (!rx_pending) begin
          report_problem("uart_irq rose although no frame was driven on uart_rx");
        end
        last_rx_byte = rx_pending_byte;
        rx_pending = 1'b0;
      end
      irq_known = uart_irq;
      irq_expected = !uart_irq_response;
      last_irq = uart_irq;

      last_read_request = read_request;
      last_write_request = write_request;
      expected_word = expected_read(rw_address, last_rx_byte, tx_busy_left != 0);
      if (tx_busy_left != 0) begin
        tx_busy_left--;
      end else if (write_request && rw_address == uart_bus_pkg::REG_TX_STATUS) begin
        tx_busy_left = TX_BUSY_CYCLES;
      end

      // sample the middle of each bit, counting from the first low level
      if (tx_offset > 0) begin
        if (tx_offset % CPB == CPB / 2) begin
          sample_index = 4'(tx_offset / CPB);
          tx_samples[sample_index] = uart_tx;
          if (sample_index == 4'd9) begin
            check_value("uart_tx frame", 32'(expected_frame(tx_pending_byte)),
                        32'(tx_samples));
            tx_offset = 0;
            tx_pending = 1'b0;
          end else begin
            tx_offset++;
          end
        end else begin
          tx_offset++;
        end
      end else if (tx_pending && last_tx && !uart_tx) begin
        tx_offset = 1;
      end else if (!tx_pending) begin
        check_value("uart_tx", 32'h1, 32'(uart_tx));
      end
      last_tx = uart_tx;

      if (note_valid) begin
        case (note_kind)
          2'd0: begin
            tx_pending = 1'b1;
            tx_pending_byte = note_byte;
          end
          2'd1: begin
            rx_pending = 1'b1;
            rx_pending_byte = note_byte;
          end
          2'd2: begin
            finish_test(int'(note_byte));
          end
          default: begin
            $display("tests ok %0d, tests with errors %0d, checks %0d, errors %0d",
                     tests_ok, tests_bad, checks_total, errors_total);
          end
        endcase
      end
    end
  end

endmodule

// ==== source/uart_peripheral.sv ====
module uart_peripheral (
  input  logic        clock,
  input  logic        reset_internal,
  input  logic [4:0]  rw_address,
  output logic [31:0] read_data,
  input  logic        read_request,
  output logic        read_response,
  input  logic [7:0]  write_data,
  input  logic        write_request,
  output logic        write_response,
  input  logic        uart_rx,
  output logic        uart_tx,
  output logic        uart_irq,
  input  logic        uart_irq_response
);

  logic       tx_start;
  logic [7:0] tx_byte;
  logic       tx_ready;
  logic [7:0] rx_byte;

  uart_bus_interface bus_interface (
    .clock          (clock),
    .reset_internal (reset_internal),
    .rw_address     (rw_address),
    .read_request   (read_request),
    .write_request  (write_request),
    .write_data     (write_data),
    .read_data      (read_data),
    .read_response  (read_response),
    .write_response (write_response),
    .tx_ready       (tx_ready),
    .rx_byte        (rx_byte),
    .tx_start       (tx_start),
    .tx_byte        (tx_byte)
  );

  uart_transmitter transmitter (
    .clock          (clock),
    .reset_internal (reset_internal),
    .tx_start       (tx_start),
    .tx_byte        (tx_byte),
    .tx_ready       (tx_ready),
    .uart_tx        (uart_tx)
  );

  // the interrupt pair goes straight to the top level ports
  uart_receiver receiver (
    .clock             (clock),
    .reset_internal    (reset_internal),
    .uart_rx           (uart_rx),
    .uart_irq_response (uart_irq_response),
    .rx_byte           (rx_byte),
    .uart_irq          (uart_irq)
  );

endmodule

// ==== source/uart_bus_interface.sv ====
module uart_bus_interface (
  input  logic        clock,
  input  logic        reset_internal,
  input  logic [4:0]  rw_address,
  input  logic        read_request,
  input  logic        write_request,
  input  logic [7:0]  write_data,
  output logic [31:0] read_data,
  output logic        read_response,
  output logic        write_response,
  input  logic        tx_ready,
  input  logic [7:0]  rx_byte,
  output logic        tx_start,
  output logic [7:0]  tx_byte
);

  uart_bus_pkg::read_word read_word_next;
  logic tx_free;
  logic tx_accept;

  // while tx_start is out the transmitter has not yet seen it,
  // so the byte in flight already counts as busy
  assign tx_free = tx_ready && !tx_start;

  assign tx_accept = write_request && tx_free &&
                     (rw_address == uart_bus_pkg::REG_TX_STATUS);

  // one cycle strobe, the byte travels with it
  always_ff @(posedge clock) begin
    if (reset_internal) begin
      tx_start <= 1'b0;
    end else begin
      tx_start <= tx_accept;
    end
  end

  always_ff @(posedge clock) begin
    if (tx_accept) begin
      tx_byte <= write_data;
    end
  end

  // unmapped addresses and idle cycles read as zero
  always_comb begin
    read_word_next = '0;
    if (read_request) begin
      case (rw_address)
        uart_bus_pkg::REG_TX_STATUS: begin
          read_word_next.status.tx_ready = tx_free;
        end
        uart_bus_pkg::REG_RX_DATA: begin
          read_word_next.rx.rx_byte = rx_byte;
        end
        default: begin
          read_word_next = '0;
        end
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (reset_internal) begin
      read_data <= '0;
    end else begin
      read_data <= read_word_next;
    end
  end

  // every request is answered one cycle later, mapped or not
  always_ff @(posedge clock) begin
    if (reset_internal) begin
      read_response  <= 1'b0;
      write_response <= 1'b0;
    end else begin
      read_response  <= read_request;
      write_response <= write_request;
    end
  end

  assert property (@(posedge clock) disable iff (reset_internal)
    read_response == $past(read_request))
    else $error("read_response is not read_request delayed by one cycle");

endmodule

// ==== source/uart_receiver.sv ====
`include "uart_consts.svh"

module uart_receiver (
  input  logic       clock,
  input  logic       reset_internal,
  input  logic       uart_rx,
  input  logic       uart_irq_response,
  output logic [7:0] rx_byte,
  output logic       uart_irq
);

  uart_line_pkg::receiver_state rx_state;
  uart_line_pkg::bit_count      rx_bit_index;
  logic [`UART_BAUD_COUNT_WIDTH-1:0] rx_baud_count;
  logic [7:0] rx_shift;
  logic rx_half_bit;
  logic rx_full_bit;

  // the first low sample counts as cycle zero of the start bit
  assign rx_half_bit =
    (rx_baud_count == `UART_BAUD_COUNT_WIDTH'(`UART_CYCLES_PER_BIT / 2 - 1));
  assign rx_full_bit =
    (rx_baud_count == `UART_BAUD_COUNT_WIDTH'(`UART_CYCLES_PER_BIT - 1));

  always_ff @(posedge clock) begin
    if (reset_internal) begin
      rx_state      <= uart_line_pkg::RX_IDLE;
      rx_bit_index  <= '0;
      rx_baud_count <= '0;
      rx_byte       <= '0;
    end else begin
      case (rx_state)
        uart_line_pkg::RX_IDLE: begin
          rx_baud_count <= '0;
          if (!uart_rx) begin
            rx_state <= uart_line_pkg::RX_START;
          end
        end
        uart_line_pkg::RX_START: begin
          // a glitch shorter than half a bit is not a start bit
          if (uart_rx) begin
            rx_state <= uart_line_pkg::RX_IDLE;
          end else if (rx_half_bit) begin
            rx_state      <= uart_line_pkg::RX_DATA;
            rx_baud_count <= '0;
            rx_bit_index  <= '0;
          end else begin
            rx_baud_count <= rx_baud_count + 1'b1;
          end
        end
        uart_line_pkg::RX_DATA: begin
          if (rx_full_bit) begin
            rx_baud_count <= '0;
            rx_bit_index  <= rx_bit_index + 4'd1;
            if (rx_bit_index == 4'd7) begin
              rx_state <= uart_line_pkg::RX_STOP;
            end
          end else begin
            rx_baud_count <= rx_baud_count + 1'b1;
          end
        end
        uart_line_pkg::RX_STOP: begin
          // the stop bit is waited out but its level is not checked
          if (rx_full_bit) begin
            rx_state      <= uart_line_pkg::RX_HOLD;
            rx_baud_count <= '0;
            rx_byte       <= rx_shift;
          end else begin
            rx_baud_count <= rx_baud_count + 1'b1;
          end
        end
        uart_line_pkg::RX_HOLD: begin
          if (uart_irq_response) begin
            rx_state <= uart_line_pkg::RX_IDLE;
          end
        end
        default: begin
          rx_state <= uart_line_pkg::RX_IDLE;
        end
      endcase
    end
  end

  // data arrives least significant bit first
  always_ff @(posedge clock) begin
    if (rx_state == uart_line_pkg::RX_DATA && rx_full_bit) begin
      rx_shift <= {uart_rx, rx_shift[7:1]};
    end
  end

  assign uart_irq = (rx_state == uart_line_pkg::RX_HOLD);

  // the interrupt is only cleared by the bus master
  assert property (@(posedge clock) disable iff (reset_internal)
    $fell(uart_irq) |-> $past(uart_irq_response))
    else $error("uart_irq dropped without uart_irq_response");

  // a new byte is always announced by a rising interrupt
  assert property (@(posedge clock) disable iff (reset_internal)
    !$stable(rx_byte) |-> $rose(uart_irq))
    else $error("rx_byte changed without a new interrupt");

endmodule

// ==== source/uart_transmitter.sv ====
`include "uart_consts.svh"

module uart_transmitter (
  input  logic       clock,
  input  logic       reset_internal,
  input  logic       tx_start,
  input  logic [7:0] tx_byte,
  output logic       tx_ready,
  output logic       uart_tx
);

  uart_line_pkg::frame_bits tx_shift;
  uart_line_pkg::bit_count  tx_bits_left;
  logic [`UART_BAUD_COUNT_WIDTH-1:0] tx_baud_count;
  logic tx_bit_done;

  assign tx_bit_done =
    (tx_baud_count == `UART_BAUD_COUNT_WIDTH'(`UART_CYCLES_PER_BIT - 1));

  // the shift register idles at all ones, so the line rests high
  // between frames and after reset
  always_ff @(posedge clock) begin
    if (reset_internal) begin
      tx_shift      <= '1;
      tx_bits_left  <= '0;
      tx_baud_count <= '0;
    end else if (tx_start) begin
      tx_shift      <= {1'b1, tx_byte, 1'b0};
      tx_bits_left  <= 4'd10;
      tx_baud_count <= '0;
    end else if (tx_bits_left != '0) begin
      if (tx_bit_done) begin
        tx_shift      <= {1'b1, tx_shift[9:1]};
        tx_bits_left  <= tx_bits_left - 4'd1;
        tx_baud_count <= '0;
      end else begin
        tx_baud_count <= tx_baud_count + 1'b1;
      end
    end
  end

  assign uart_tx = tx_shift[0];

  // ready again once the last stop bit period has run out
  assign tx_ready = (tx_bits_left == '0);

  // the bus side must hold off a new byte until the frame is done
  assert property (@(posedge clock) disable iff (reset_internal)
    !(tx_start && !tx_ready))
    else $error("tx_start raised while a frame is still being sent");

endmodule

// ==== source/uart_line_pkg.sv ====
package uart_line_pkg;

  // receiver FSM
  // RX_HOLD keeps the interrupt up and ignores the line
  typedef enum logic [2:0] {
    RX_IDLE,
    RX_START,
    RX_DATA,
    RX_STOP,
    RX_HOLD
  } receiver_state;

  // counts bits of a frame, up to ten
  typedef logic [3:0] bit_count;

  // one 8N1 frame as it is shifted out, bit 0 first
  // {stop bit, data byte, start bit}
  typedef logic [9:0] frame_bits;

endpackage

// ==== source/uart_bus_pkg.sv ====
package uart_bus_pkg;

  // word addresses seen on rw_address
  typedef enum logic [4:0] {
    REG_TX_STATUS = 5'h00,
    REG_RX_DATA   = 5'h04
  } register_address;

  // the read word is decoded either as the transmitter status
  // or as the last received byte, depending on the address
  typedef union packed {
    struct packed {
      logic [30:0] pad;
      logic        tx_ready;
    } status;
    struct packed {
      logic [23:0] pad;
      logic [7:0]  rx_byte;
    } rx;
  } read_word;

endpackage

// ==== source/uart_consts.svh ====
`ifndef UART_CONSTS_SVH
`define UART_CONSTS_SVH

// system clock in Hz, a 20 ns period
`define UART_CLOCK_FREQUENCY 50000000

// line rate in bits per second
// kept high so that a frame takes only a hundred clock cycles
`define UART_BAUD_RATE 5000000

// number of clock cycles that one bit stays on the line
`define UART_CYCLES_PER_BIT (`UART_CLOCK_FREQUENCY / `UART_BAUD_RATE)

// width of the transmit and receive baud counters
// must hold UART_CYCLES_PER_BIT - 1
`define UART_BAUD_COUNT_WIDTH 16

`endif
